//--- compile.f
source/game_pkg.sv
source/canvas_pkg.sv
source/step_decode.sv
source/ghost_patrol.sv
source/actor_update.sv
source/sprite_writer.sv
source/maze_engine.sv
test/maze_checker.sv
test/maze_engine_tb.sv

//--- source/actor_update.sv
`timescale 1ns/1ps

module actor_update #(
    parameter int G1_START_COL  = 5,
    parameter int G1_PATROL_ROW = 1,
    parameter int G1_PATH_LEN   = 63,
    parameter int G2_START_COL  = 0,
    parameter int G2_PATROL_ROW = 6,
    parameter int G2_PATH_LEN   = 78,
    parameter int G3_START_COL  = 20,
    parameter int G3_PATROL_ROW = 11,
    parameter int G3_PATH_LEN   = 50
) (
    input  logic          clock,
    input  logic          resetn,
    input  logic          move_valid,
    input  logic [1:0]    move_dx,
    input  logic [1:0]    move_dy,
    output game_pkg::col_t player_col,
    output game_pkg::row_t player_row,
    output logic          collided,
    output logic          render_start
);

    import game_pkg::*;

    localparam col_t COL_MAX = col_t'(GRID_COLS - 1);
    localparam row_t ROW_MAX = row_t'(GRID_ROWS - 1);

    col_t g1_col, g2_col, g3_col;
    row_t g1_row, g2_row, g3_row;
    logic moved;   // Move applied on the previous edge
    logic hit;

    // Ghosts step together with the player
    ghost_patrol #(
        .START_COL (G1_START_COL),
        .PATROL_ROW(G1_PATROL_ROW),
        .PATH_LEN  (G1_PATH_LEN)
    ) ghost1_inst (
        .clock    (clock),
        .resetn   (resetn),
        .advance  (move_valid),
        .ghost_col(g1_col),
        .ghost_row(g1_row)
    );

    ghost_patrol #(
        .START_COL (G2_START_COL),
        .PATROL_ROW(G2_PATROL_ROW),
        .PATH_LEN  (G2_PATH_LEN)
    ) ghost2_inst (
        .clock    (clock),
        .resetn   (resetn),
        .advance  (move_valid),
        .ghost_col(g2_col),
        .ghost_row(g2_row)
    );

    ghost_patrol #(
        .START_COL (G3_START_COL),
        .PATROL_ROW(G3_PATROL_ROW),
        .PATH_LEN  (G3_PATH_LEN)
    ) ghost3_inst (
        .clock    (clock),
        .resetn   (resetn),
        .advance  (move_valid),
        .ghost_col(g3_col),
        .ghost_row(g3_row)
    );

    // Player move, clamped at the grid border
    always_ff @(posedge clock) begin
        if (!resetn) begin
            player_col <= PLAYER_START_COL;
            player_row <= PLAYER_START_ROW;
        end else if (move_valid) begin
            if (move_dx == 2'b01 && player_col != COL_MAX)
                player_col <= player_col + 1'b1;
            else if (move_dx == 2'b11 && player_col != '0)
                player_col <= player_col - 1'b1;
            if (move_dy == 2'b01 && player_row != ROW_MAX)
                player_row <= player_row + 1'b1;   // Down
            else if (move_dy == 2'b11 && player_row != '0)
                player_row <= player_row - 1'b1;   // Up
        end
    end

    // Same cell as any ghost
    assign hit = (player_col == g1_col && player_row == g1_row) ||
                 (player_col == g2_col && player_row == g2_row) ||
                 (player_col == g3_col && player_row == g3_row);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            moved        <= 1'b0;
            collided     <= 1'b0;
            render_start <= 1'b0;
        end else begin
            moved        <= move_valid;
            render_start <= moved;     // Positions settled, draw now
            if (moved)
                collided <= hit;
        end
    end

endmodule

//--- source/canvas_pkg.sv
package canvas_pkg;

    // Frame buffer geometry
    parameter int CANVAS_WIDTH  = 160;
    parameter int CANVAS_HEIGHT = 120;

    // Square cell edge in pixels, also the sprite edge
    parameter int CELL_PIXELS = 5;

    // Linear address into the 160x120 buffer
    typedef logic [14:0] pixel_addr_t;

    // 4 bits each of red, green, blue
    typedef logic [11:0] color_t;

    parameter color_t PLAYER_COLOR = 12'hfa8;   // Warm yellow

    // Pixel offset inside a sprite, 0..4
    typedef logic [2:0] offset_t;

endpackage

//--- source/game_pkg.sv
package game_pkg;

    // Maze size in cells
    parameter int GRID_COLS = 29;
    parameter int GRID_ROWS = 13;

    // Cell coordinates
    typedef logic [4:0] col_t;   // 0..28
    typedef logic [3:0] row_t;   // 0..12

    // Step direction, encoded as the keypad decoder delivers it
    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_DOWN  = 2'd2,
        DIR_RIGHT = 2'd3
    } dir_t;

    // Player cell after reset
    parameter col_t PLAYER_START_COL = 5'd1;
    parameter row_t PLAYER_START_ROW = 4'd1;

    // Ghost patrol step counter, longest path is well under 128
    typedef logic [6:0] path_idx_t;

endpackage

//--- source/ghost_patrol.sv
`timescale 1ns/1ps

module ghost_patrol #(
    parameter int START_COL  = 0,
    parameter int PATROL_ROW = 0,
    parameter int PATH_LEN   = 29
) (
    input  logic          clock,
    input  logic          resetn,
    input  logic          advance,
    output game_pkg::col_t ghost_col,
    output game_pkg::row_t ghost_row
);

    import game_pkg::*;

    // Start cell folded into the grid
    localparam col_t FIRST_COL = col_t'(START_COL % GRID_COLS);
    localparam col_t COL_MAX   = col_t'(GRID_COLS - 1);
    localparam path_idx_t IDX_LAST = path_idx_t'(PATH_LEN - 1);

    path_idx_t path_idx;   // Steps taken along the path

    // Column tracks the index so no modulo is needed per step
    always_ff @(posedge clock) begin
        if (!resetn) begin
            path_idx  <= '0;
            ghost_col <= FIRST_COL;
        end else if (advance) begin
            if (path_idx == IDX_LAST) begin
                path_idx  <= '0;          // Path restarts
                ghost_col <= FIRST_COL;
            end else begin
                path_idx <= path_idx + 1'b1;
                if (ghost_col == COL_MAX)
                    ghost_col <= '0;      // Wrap to left edge
                else
                    ghost_col <= ghost_col + 1'b1;
            end
        end
    end

    // Each ghost patrols a single row
    assign ghost_row = row_t'(PATROL_ROW);

endmodule

//--- source/maze_engine.sv
`timescale 1ns/1ps

module maze_engine #(
    parameter int G1_START_COL  = 5,
    parameter int G1_PATROL_ROW = 1,
    parameter int G1_PATH_LEN   = 63,
    parameter int G2_START_COL  = 0,
    parameter int G2_PATROL_ROW = 6,
    parameter int G2_PATH_LEN   = 78,
    parameter int G3_START_COL  = 20,
    parameter int G3_PATROL_ROW = 11,
    parameter int G3_PATH_LEN   = 50
) (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    step,
    input  game_pkg::dir_t          direction,
    output game_pkg::col_t          player_col,
    output game_pkg::row_t          player_row,
    output logic                    collided,
    output logic                    wren,
    output canvas_pkg::pixel_addr_t addr,
    output canvas_pkg::color_t      data,
    output logic                    finished
);

    logic       move_valid;
    logic [1:0] move_dx;
    logic [1:0] move_dy;
    logic       render_start;
    logic       render_busy;   // Back from the writer, gates new steps

    // Decode stage
    step_decode step_decode_inst (
        .clock      (clock),
        .resetn     (resetn),
        .step       (step),
        .direction  (direction),
        .render_busy(render_busy),
        .move_valid (move_valid),
        .move_dx    (move_dx),
        .move_dy    (move_dy)
    );

    // Execute stage, ghost paths set here
    actor_update #(
        .G1_START_COL (G1_START_COL),
        .G1_PATROL_ROW(G1_PATROL_ROW),
        .G1_PATH_LEN  (G1_PATH_LEN),
        .G2_START_COL (G2_START_COL),
        .G2_PATROL_ROW(G2_PATROL_ROW),
        .G2_PATH_LEN  (G2_PATH_LEN),
        .G3_START_COL (G3_START_COL),
        .G3_PATROL_ROW(G3_PATROL_ROW),
        .G3_PATH_LEN  (G3_PATH_LEN)
    ) actor_update_inst (
        .clock       (clock),
        .resetn      (resetn),
        .move_valid  (move_valid),
        .move_dx     (move_dx),
        .move_dy     (move_dy),
        .player_col  (player_col),
        .player_row  (player_row),
        .collided    (collided),
        .render_start(render_start)
    );

    // Result stage
    sprite_writer sprite_writer_inst (
        .clock       (clock),
        .resetn      (resetn),
        .render_start(render_start),
        .player_col  (player_col),
        .player_row  (player_row),
        .render_busy (render_busy),
        .wren        (wren),
        .addr        (addr),
        .data        (data),
        .finished    (finished)
    );

endmodule

//--- source/sprite_writer.sv
`timescale 1ns/1ps

module sprite_writer (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  render_start,
    input  game_pkg::col_t        player_col,
    input  game_pkg::row_t        player_row,
    output logic                  render_busy,
    output logic                  wren,
    output canvas_pkg::pixel_addr_t addr,
    output canvas_pkg::color_t    data,
    output logic                  finished
);

    import canvas_pkg::*;

    localparam offset_t LAST = offset_t'(CELL_PIXELS - 1);

    offset_t    dx, dy;    // Current slot, dx runs fastest
    logic       active;    // Slots 1..24 in progress
    logic       slot_on;   // A pixel slot this cycle
    logic       corner;
    logic [7:0] pix_x;     // Canvas column
    logic [6:0] pix_y;     // Canvas row

    // First slot rides on the start pulse itself
    assign slot_on = render_start || active;

    // Disc shape, skip the four corners
    assign corner = (dx == '0 || dx == LAST) && (dy == '0 || dy == LAST);

    always_comb begin
        pix_x = 8'(player_col) * 8'(CELL_PIXELS) + 8'(dx);
        pix_y = 7'(player_row) * 7'(CELL_PIXELS) + 7'(dy);
        addr  = pixel_addr_t'(pix_y) * pixel_addr_t'(CANVAS_WIDTH) + pixel_addr_t'(pix_x);
    end

    assign wren = slot_on && !corner;
    assign data = PLAYER_COLOR;   // Solid fill

    // Busy until the finished cycle is over
    assign render_busy = slot_on || finished;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            dx       <= '0;
            dy       <= '0;
            active   <= 1'b0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (slot_on) begin
                if (dx == LAST) begin
                    dx <= '0;
                    if (dy == LAST) begin
                        dy       <= '0;     // Back to idle
                        active   <= 1'b0;
                        finished <= 1'b1;   // One cycle pulse
                    end else begin
                        dy     <= dy + 1'b1;
                        active <= 1'b1;
                    end
                end else begin
                    dx     <= dx + 1'b1;
                    active <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/step_decode.sv
`timescale 1ns/1ps

module step_decode (
    input  logic          clock,
    input  logic          resetn,
    input  logic          step,
    input  game_pkg::dir_t direction,
    input  logic          render_busy,
    output logic          move_valid,
    output logic [1:0]    move_dx,
    output logic [1:0]    move_dy
);

    import game_pkg::*;

    logic step_q;     // Accepted step, first stage
    dir_t dir_q;      // Direction captured with it
    logic pending;    // Step in flight before the render begins
    logic accept;

    // One step per render, drop anything while in flight
    assign accept = step && !render_busy && !pending;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            step_q     <= 1'b0;
            move_valid <= 1'b0;
            pending    <= 1'b0;
        end else begin
            step_q     <= accept;
            move_valid <= step_q;   // Second stage
            if (accept)
                pending <= 1'b1;
            else if (render_busy)
                pending <= 1'b0;    // Writer now holds busy
        end
    end

    // Unit move decode, signed two bit values
    always_ff @(posedge clock) begin
        if (accept)
            dir_q <= direction;
        if (step_q) begin
            case (dir_q)
                DIR_UP: begin
                    move_dx <= 2'b00;
                    move_dy <= 2'b11;   // -1
                end
                DIR_LEFT: begin
                    move_dx <= 2'b11;
                    move_dy <= 2'b00;
                end
                DIR_DOWN: begin
                    move_dx <= 2'b00;
                    move_dy <= 2'b01;   // +1
                end
                default: begin          // Right
                    move_dx <= 2'b01;
                    move_dy <= 2'b00;
                end
            endcase
        end
    end

endmodule

//--- test/maze_checker.sv
`timescale 1ns/1ps

module maze_checker (
    input logic        clock,
    input logic        resetn,
    input logic [4:0]  player_col,
    input logic [3:0]  player_row,
    input logic        collided,
    input logic        wren,
    input logic [14:0] addr,
    input logic [11:0] data,
    input logic        finished
);

    localparam logic [11:0] SPRITE_COLOR = 12'hfa8;
    localparam int FINISH_DELAY = 29;   // Step edge to finished edge

    int          cycle;          // Rising edges so far
    int          step_edge;      // Edge that samples the accepted step
    int          fin_edge;
    int          fin_count;      // Finished pulses since the step
    int          late_writes;    // Writes seen after finished
    logic        fin_coll;       // collided as seen with finished
    logic [14:0] seen_q[$];
    logic [14:0] want_q[$];
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          hits;           // Collision outcomes seen on the DUT
    int          misses;

    task automatic report_value(input string name, input logic [31:0] want,
                                input logic [31:0] got);
        $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    // Pixel stream and finished pulse sampled at the rising edge
    always @(posedge clock) begin
        cycle = cycle + 1;
        if (resetn && wren) begin
            if (fin_count > 0)
                late_writes++;
            seen_q.push_back(addr);
            if (data !== SPRITE_COLOR)
                report_value("data", SPRITE_COLOR, data);
        end
        if (resetn && finished) begin
            fin_count++;
            fin_edge = cycle;
            fin_coll = collided;   // Latched with the pulse
        end
    end

    // Called on the falling edge that raises step
    task automatic note_step();
        step_edge   = cycle + 1;
        fin_count   = 0;
        late_writes = 0;
        seen_q.delete();
        want_q.delete();
    endtask

    task automatic expect_addr(input logic [14:0] a);
        want_q.push_back(a);
    endtask

    task automatic check_idle(input logic [4:0] want_col, input logic [3:0] want_row);
        if (player_col !== want_col)
            report_value("player_col", want_col, player_col);
        if (player_row !== want_row)
            report_value("player_row", want_row, player_row);
        if (wren !== 1'b0)
            report_value("wren", 0, wren);
        if (finished !== 1'b0)
            report_value("finished", 0, finished);
        if (collided !== 1'b0)
            report_value("collided", 0, collided);
    endtask

    task automatic check_step(input logic [4:0] want_col, input logic [3:0] want_row,
                              input logic want_coll);
        if (player_col !== want_col)
            report_value("player_col", want_col, player_col);
        if (player_row !== want_row)
            report_value("player_row", want_row, player_row);
        if (fin_count != 1) begin
            report_problem($sformatf("%0d finished pulses after one step", fin_count));
        end else begin
            if (fin_edge != step_edge + FINISH_DELAY)
                report_problem($sformatf("finished came %0d cycles after the step",
                                         fin_edge - step_edge));
            if (fin_coll !== want_coll)
                report_value("collided", want_coll, fin_coll);
            if (fin_coll === 1'b1)
                hits++;
            else
                misses++;
        end
        // Stream order is dy outer and dx inner like the expected list
        if (seen_q.size() != want_q.size())
            report_problem($sformatf("%0d pixel writes instead of %0d",
                                     seen_q.size(), want_q.size()));
        else
            foreach (want_q[i])
                if (seen_q[i] !== want_q[i])
                    report_value("addr", want_q[i], seen_q[i]);
        if (late_writes != 0)
            report_problem("pixel write after the finished pulse");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("[ok]    %s", name);
        end else begin
            tests_failed++;
            $display("[error] %s, %0d mismatches", name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic summarize(output bit clean);
        if (hits == 0 || misses == 0)
            report_problem("the DUT never showed both collided values");
        total_errors += test_errors;
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        clean = (total_errors == 0);
    endtask

endmodule

//--- test/maze_engine_tb.sv
`timescale 1ns/1ps

module maze_engine_tb;

    import game_pkg::*;

    logic        clock = 1'b0;
    logic        resetn;
    logic        step;
    dir_t        direction;
    logic [4:0]  player_col;
    logic [3:0]  player_row;
    logic        collided;
    logic        wren;
    logic [14:0] addr;
    logic [11:0] data;
    logic        finished;

    // Stimulus table, one row per test
    dir_t stim_dir[7]   = '{DIR_RIGHT, DIR_UP, DIR_DOWN, DIR_LEFT, DIR_UP, DIR_DOWN, DIR_RIGHT};
    int   stim_count[7] = '{55, 3, 15, 32, 6, 1, 3};
    bit   stim_hold[7]  = '{0, 0, 0, 0, 0, 1, 0};   // Step held high through the render

    // Patrol rule per ghost, top level defaults
    int ghost_start[3] = '{5, 0, 20};
    int ghost_row[3]   = '{1, 6, 11};
    int ghost_len[3]   = '{63, 78, 50};

    int          model_col;
    int          model_row;
    int          ghost_idx[3];
    bit          model_coll;
    logic [31:0] rng_state;

    always #20 clock = ~clock;   // 40 ns period

    maze_engine maze_engine_inst (
        .clock     (clock),
        .resetn    (resetn),
        .step      (step),
        .direction (direction),
        .player_col(player_col),
        .player_row(player_row),
        .collided  (collided),
        .wren      (wren),
        .addr      (addr),
        .data      (data),
        .finished  (finished)
    );

    maze_checker maze_checker_inst (
        .clock     (clock),
        .resetn    (resetn),
        .player_col(player_col),
        .player_row(player_row),
        .collided  (collided),
        .wren      (wren),
        .addr      (addr),
        .data      (data),
        .finished  (finished)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Reference model, clamp at the border, then ghosts step and collide
    function automatic void model_step(input dir_t d);
        case (d)
            DIR_UP:    if (model_row > 0) model_row--;
            DIR_DOWN:  if (model_row < GRID_ROWS - 1) model_row++;
            DIR_LEFT:  if (model_col > 0) model_col--;
            default:   if (model_col < GRID_COLS - 1) model_col++;
        endcase
        model_coll = 1'b0;
        for (int g = 0; g < 3; g++) begin
            ghost_idx[g] = (ghost_idx[g] + 1) % ghost_len[g];
            if (model_col == (ghost_start[g] + ghost_idx[g]) % GRID_COLS &&
                model_row == ghost_row[g])
                model_coll = 1'b1;
        end
    endfunction

    // 5x5 disc, corners skipped
    task automatic expect_sprite();
        for (int dy = 0; dy < 5; dy++)
            for (int dx = 0; dx < 5; dx++)
                if (!((dx == 0 || dx == 4) && (dy == 0 || dy == 4)))
                    maze_checker_inst.expect_addr((model_row * 5 + dy) * 160 +
                                                  model_col * 5 + dx);
    endtask

    task automatic run_step(input dir_t d, input bit hold, output bit ok);
        int waited;
        direction = d;
        step      = 1'b1;
        maze_checker_inst.note_step();
        model_step(d);
        expect_sprite();
        @(negedge clock);
        if (!hold)
            step = 1'b0;
        waited = 0;
        while (finished !== 1'b1 && waited < 100) begin
            @(negedge clock);
            waited++;
        end
        ok = (waited < 100);
        if (!ok)
            maze_checker_inst.report_problem("no finished pulse within 100 cycles");
        if (hold)
            @(negedge clock);   // Also presses on the finished edge
        step = 1'b0;
        repeat (3) @(negedge clock);   // Idle gap catches stray writes
        if (ok)
            maze_checker_inst.check_step(model_col, model_row, model_coll);
    endtask

    initial begin : main
        bit ok;
        bit clean;
        resetn    = 1'b0;
        step      = 1'b0;
        direction = DIR_UP;
        model_col = 1;
        model_row = 1;
        ghost_idx = '{0, 0, 0};
        rng_state = 32'h41fa_9534;
        repeat (8) @(negedge clock);
        resetn = 1'b1;
        @(negedge clock);
        maze_checker_inst.check_idle(5'd1, 4'd1);
        maze_checker_inst.finish_test("reset state");
        ok = 1'b1;
        for (int r = 0; r < 7 && ok; r++) begin
            for (int n = 0; n < stim_count[r] && ok; n++)
                run_step(stim_dir[r], stim_hold[r], ok);
            maze_checker_inst.finish_test($sformatf("row %0d, %s x%0d", r,
                                                    stim_dir[r].name(), stim_count[r]));
        end
        for (int n = 0; n < 40 && ok; n++) begin
            rng_state = xorshift32(rng_state);
            run_step(dir_t'(rng_state[1:0]), 1'b0, ok);
        end
        maze_checker_inst.finish_test("random walk, 40 steps");
        maze_checker_inst.summarize(clean);
        if (clean && ok)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
